// File: rtl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [cpu_pkg::word_size-1:0] i_addr,
    input  logic [cpu_pkg::word_size-1:0] i_data,
    output logic                          d_req,
    output logic                          d_we,
    output logic [cpu_pkg::word_size-1:0] d_addr,
    output logic [cpu_pkg::word_size-1:0] d_wdata,
    input  logic                          d_ack,
    input  logic [cpu_pkg::word_size-1:0] d_rdata,
    output logic                          out_valid,
    output logic [cpu_pkg::word_size-1:0] out_data,
    output logic                          halted
);
    import cpu_pkg::*;

    logic [word_size-1:0] pc;
    logic [word_size-1:0] target;
    logic [word_size-1:0] load_data;
    logic [word_size-1:0] rdata1;
    logic [word_size-1:0] rdata2;
    logic redirect;
    logic mem_busy;
    logic fetch_halted;  // HLT has left ID, fetch stays frozen
    logic wb_fresh;      // MEM/WB took a new entry last edge
    logic pc_hold;
    logic if_id_stall;
    logic if_id_flush;
    logic id_ex_stall;
    logic id_ex_flush;
    logic late_stall;

    if_id_t  if_id_d, if_id_q;
    id_ex_t  id_ex_d, id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!pc_hold) begin
            pc <= redirect ? target : pc + word_size'(1);
        end
    end

    assign i_addr  = pc;
    assign if_id_d = '{pc: pc, instr: i_data};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk, .rst_n, .stall(if_id_stall), .flush(if_id_flush), .d(if_id_d), .q(if_id_q));

    reg_file reg_file_inst (
        .clk, .rst_n,
        .rs(if_id_q.instr[rs_msb:rs_lsb]), .rt(if_id_q.instr[rt_msb:rt_lsb]),
        .we(mem_wb_q.reg_wr && wb_fresh), .wa(mem_wb_q.wr_addr), .wd(mem_wb_q.wb_data),
        .rdata1, .rdata2);

    decoder decoder_inst (
        .instr(if_id_q.instr), .pc(if_id_q.pc), .rdata1, .rdata2, .id_ex(id_ex_d));

    hazard_unit hazard_unit_inst (
        .id_rs(id_ex_d.rs), .id_rt(id_ex_d.rt), .id_is_halt(id_ex_d.is_halt || fetch_halted),
        .ex_mem_rd(id_ex_q.mem_rd), .ex_wr_addr(id_ex_q.wr_addr), .redirect,
        .mem_busy, .pc_hold, .if_id_stall, .if_id_flush, .id_ex_stall, .id_ex_flush,
        .late_stall);

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk, .rst_n, .stall(id_ex_stall), .flush(id_ex_flush), .d(id_ex_d), .q(id_ex_q));

    exec_unit exec_unit_inst (
        .id_ex(id_ex_q), .fwd_mem(ex_mem_q), .fwd_wb(mem_wb_q), .ex_mem(ex_mem_d),
        .redirect, .target);

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk, .rst_n, .stall(late_stall), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q));

    mem_port mem_port_inst (
        .clk, .rst_n, .ex_mem(ex_mem_q), .d_ack, .d_rdata, .d_req, .d_we, .d_addr,
        .d_wdata, .busy(mem_busy), .load_data);

    // write-back select
    assign mem_wb_d = '{
        wb_data: ex_mem_q.mem_rd ? load_data : ex_mem_q.alu_out,
        wr_addr: ex_mem_q.wr_addr,
        reg_wr:  ex_mem_q.reg_wr,
        is_out:  ex_mem_q.is_out,
        is_halt: ex_mem_q.is_halt
    };

    // held during memory waits so EX keeps its WB forwarding source
    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk, .rst_n, .stall(late_stall), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_halted <= 1'b0;
            halted       <= 1'b0;
            wb_fresh     <= 1'b0;
        end else begin
            if (id_ex_d.is_halt && !id_ex_stall && !id_ex_flush) begin
                fetch_halted <= 1'b1;
            end
            if (mem_wb_q.is_halt) begin
                halted <= 1'b1;  // sticky until reset
            end
            wb_fresh <= !late_stall;
        end
    end

    assign out_valid = mem_wb_q.is_out && wb_fresh;  // one pulse per WWD
    assign out_data  = mem_wb_q.wb_data;

endmodule

`default_nettype wire

// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_size  = 16;
    localparam int reg_addr_w = 2;

    // instruction field positions
    localparam int op_msb  = 15;
    localparam int op_lsb  = 12;
    localparam int rs_msb  = 11;
    localparam int rs_lsb  = 10;
    localparam int rt_msb  = 9;
    localparam int rt_lsb  = 8;
    localparam int rd_msb  = 7;
    localparam int rd_lsb  = 6;
    localparam int imm_msb = 7;   // imm8, sign-extended
    localparam int jmp_msb = 11;  // jump target field is 11..0

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_ORR,
        OP_ADI,
        OP_LWD,
        OP_SWD,
        OP_BNE,
        OP_JMP,
        OP_WWD,
        OP_HLT
    } opcode_t;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} alu_op_t;

    typedef struct packed {
        logic [word_size-1:0] pc;
        logic [word_size-1:0] instr;
    } if_id_t;

    // decoded instruction on its way into EX
    typedef struct packed {
        logic [word_size-1:0]  pc;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] wr_addr;
        logic [word_size-1:0]  rdata1;
        logic [word_size-1:0]  rdata2;
        logic [word_size-1:0]  imm;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_wr;
        logic                  is_branch;
        logic                  is_jump;
        logic                  is_out;
        logic                  is_halt;
    } id_ex_t;

    typedef struct packed {
        logic [word_size-1:0]  pc;
        logic [word_size-1:0]  alu_out;    // also the memory address
        logic [word_size-1:0]  store_data;
        logic [reg_addr_w-1:0] wr_addr;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_wr;
        logic                  is_out;
        logic                  is_halt;
    } ex_mem_t;

    typedef struct packed {
        logic [word_size-1:0]  wb_data;
        logic [reg_addr_w-1:0] wr_addr;
        logic                  reg_wr;
        logic                  is_out;
        logic                  is_halt;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  logic [cpu_pkg::word_size-1:0] instr,
    input  logic [cpu_pkg::word_size-1:0] pc,
    input  logic [cpu_pkg::word_size-1:0] rdata1,
    input  logic [cpu_pkg::word_size-1:0] rdata2,
    output cpu_pkg::id_ex_t               id_ex
);
    import cpu_pkg::*;

    opcode_t               op;
    logic [reg_addr_w-1:0] rd;
    logic [word_size-1:0]  imm_sx;
    logic [word_size-1:0]  jmp_field;

    assign op        = opcode_t'(instr[op_msb:op_lsb]);
    assign rd        = instr[rd_msb:rd_lsb];
    assign imm_sx    = {{(word_size-imm_msb-1){instr[imm_msb]}}, instr[imm_msb:0]};
    assign jmp_field = {{(word_size-jmp_msb-1){1'b0}}, instr[jmp_msb:0]};

    always_comb begin
        id_ex        = '0;
        id_ex.pc     = pc;
        id_ex.rs     = instr[rs_msb:rs_lsb];
        id_ex.rt     = instr[rt_msb:rt_lsb];
        id_ex.rdata1 = rdata1;
        id_ex.rdata2 = rdata2;
        id_ex.imm    = imm_sx;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_ORR: begin
                id_ex.wr_addr = rd;
                id_ex.reg_wr  = 1'b1;
                id_ex.alu_op  = (op == OP_SUB) ? ALU_SUB :
                                (op == OP_AND) ? ALU_AND :
                                (op == OP_ORR) ? ALU_OR  : ALU_ADD;
            end
            OP_ADI, OP_LWD: begin
                id_ex.wr_addr = id_ex.rt;    // I-type writes rt
                id_ex.reg_wr  = 1'b1;
                id_ex.use_imm = 1'b1;
                id_ex.mem_rd  = (op == OP_LWD);
            end
            OP_SWD: begin
                id_ex.use_imm = 1'b1;    // base + offset
                id_ex.mem_wr  = 1'b1;
            end
            OP_BNE: id_ex.is_branch = 1'b1;
            OP_JMP: begin
                id_ex.is_jump = 1'b1;
                id_ex.imm     = jmp_field;
            end
            OP_WWD: id_ex.is_out  = 1'b1;
            OP_HLT: id_ex.is_halt = 1'b1;
            default: id_ex = '0;  // NOP and unused opcodes
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
    input  cpu_pkg::id_ex_t               id_ex,
    input  cpu_pkg::ex_mem_t              fwd_mem,
    input  cpu_pkg::mem_wb_t              fwd_wb,
    output cpu_pkg::ex_mem_t              ex_mem,
    output logic                          redirect,
    output logic [cpu_pkg::word_size-1:0] target
);
    import cpu_pkg::*;

    logic [word_size-1:0] op_a;
    logic [word_size-1:0] op_b;
    logic [word_size-1:0] alu_b;
    logic [word_size-1:0] alu_res;

    // newest writer wins, MEM before WB
    always_comb begin
        if (fwd_mem.reg_wr && fwd_mem.wr_addr == id_ex.rs) begin
            op_a = fwd_mem.alu_out;
        end else if (fwd_wb.reg_wr && fwd_wb.wr_addr == id_ex.rs) begin
            op_a = fwd_wb.wb_data;
        end else begin
            op_a = id_ex.rdata1;
        end
        if (fwd_mem.reg_wr && fwd_mem.wr_addr == id_ex.rt) begin
            op_b = fwd_mem.alu_out;
        end else if (fwd_wb.reg_wr && fwd_wb.wr_addr == id_ex.rt) begin
            op_b = fwd_wb.wb_data;
        end else begin
            op_b = id_ex.rdata2;
        end
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_res = op_a + alu_b;
            ALU_SUB: alu_res = op_a - alu_b;
            ALU_AND: alu_res = op_a & alu_b;
            ALU_OR:  alu_res = op_a | alu_b;
        endcase
    end

    // BNE taken or JMP, resolved here so two slots get squashed
    assign redirect = (id_ex.is_branch && op_a != op_b) || id_ex.is_jump;
    assign target   = id_ex.is_jump ?
                      {id_ex.pc[word_size-1:jmp_msb+1], id_ex.imm[jmp_msb:0]} :
                      id_ex.pc + word_size'(1) + id_ex.imm;

    assign ex_mem = '{
        pc:         id_ex.pc,
        alu_out:    id_ex.is_out ? op_a : alu_res,  // WWD passes rs through
        store_data: op_b,
        wr_addr:    id_ex.wr_addr,
        mem_rd:     id_ex.mem_rd,
        mem_wr:     id_ex.mem_wr,
        reg_wr:     id_ex.reg_wr,
        is_out:     id_ex.is_out,
        is_halt:    id_ex.is_halt
    };

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rs,
    input  logic [cpu_pkg::reg_addr_w-1:0] id_rt,
    input  logic                           id_is_halt,
    input  logic                           ex_mem_rd,
    input  logic [cpu_pkg::reg_addr_w-1:0] ex_wr_addr,
    input  logic                           redirect,
    input  logic                           mem_busy,
    output logic                           pc_hold,
    output logic                           if_id_stall,
    output logic                           if_id_flush,
    output logic                           id_ex_stall,
    output logic                           id_ex_flush,
    output logic                           late_stall
);

    logic load_use;

    assign load_use = ex_mem_rd && (ex_wr_addr == id_rs || ex_wr_addr == id_rt);

    always_comb begin
        pc_hold     = 1'b0;
        if_id_stall = 1'b0;
        if_id_flush = 1'b0;
        id_ex_stall = 1'b0;
        id_ex_flush = 1'b0;
        late_stall  = mem_busy;
        if (mem_busy) begin
            pc_hold     = 1'b1;  // whole pipe waits on data memory
            if_id_stall = 1'b1;
            id_ex_stall = 1'b1;
        end else if (redirect) begin
            if_id_flush = 1'b1;
            id_ex_flush = 1'b1;
        end else if (load_use) begin
            pc_hold     = 1'b1;
            if_id_stall = 1'b1;
            id_ex_flush = 1'b1;  // one bubble into EX
        end else if (id_is_halt) begin
            pc_hold     = 1'b1;
            if_id_flush = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_port.sv
`timescale 1ns/100ps
`default_nettype none

module mem_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  cpu_pkg::ex_mem_t              ex_mem,
    input  logic                          d_ack,
    input  logic [cpu_pkg::word_size-1:0] d_rdata,
    output logic                          d_req,
    output logic                          d_we,
    output logic [cpu_pkg::word_size-1:0] d_addr,
    output logic [cpu_pkg::word_size-1:0] d_wdata,
    output logic                          busy,
    output logic [cpu_pkg::word_size-1:0] load_data
);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_ACK, ST_WAIT_RELEASE, ST_DONE} state_t;

    state_t state;
    logic   access;

    assign access  = ex_mem.mem_rd || ex_mem.mem_wr;
    assign d_req   = (state == ST_WAIT_ACK);
    assign d_we    = ex_mem.mem_wr;
    assign d_addr  = ex_mem.alu_out;     // held steady by the stalled EX/MEM
    assign d_wdata = ex_mem.store_data;
    assign busy    = (state == ST_IDLE && access) || state == ST_WAIT_ACK ||
                     state == ST_WAIT_RELEASE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:         if (access) state <= ST_WAIT_ACK;
                ST_WAIT_ACK:     if (d_ack) state <= ST_WAIT_RELEASE;
                ST_WAIT_RELEASE: if (!d_ack) state <= ST_DONE;
                ST_DONE:         state <= ST_IDLE;  // access retires this cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT_ACK && d_ack) begin
            load_data <= d_rdata;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        d_req |=> !d_req || $stable(d_addr));

endmodule

`default_nettype wire

// File: rtl/pipe_reg.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= '0;  // zero payload is a bubble
        end else if (!stall) begin
            q <= d;
        end
    end

    // hazard priority never asks a stage to stall and flush at once
    a_no_stall_flush: assert property (@(posedge clk) disable iff (!rst_n)
        !(stall && flush));

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt,
    input  logic                           we,
    input  logic [cpu_pkg::reg_addr_w-1:0] wa,
    input  logic [cpu_pkg::word_size-1:0]  wd,
    output logic [cpu_pkg::word_size-1:0]  rdata1,
    output logic [cpu_pkg::word_size-1:0]  rdata2
);
    import cpu_pkg::*;

    logic [word_size-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-through, WB result visible to ID in the same cycle
    assign rdata1 = (we && wa == rs) ? wd : regs[rs];
    assign rdata2 = (we && wa == rt) ? wd : regs[rt];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module cpu_tb -o cpu_sim
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: src.f
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/exec_unit.sv
rtl/hazard_unit.sv
rtl/mem_port.sv
rtl/cpu_core.sv
tb/tb_clock.sv
tb/cpu_tb.sv

// File: tb/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;
    import cpu_pkg::*;

    logic                 clk;
    logic                 rst_n = 1'b0;
    logic [word_size-1:0] i_addr;
    logic [word_size-1:0] i_data;
    logic                 d_req;
    logic                 d_we;
    logic [word_size-1:0] d_addr;
    logic [word_size-1:0] d_wdata;
    logic                 d_ack = 1'b0;
    logic [word_size-1:0] d_rdata = '0;
    logic                 out_valid;
    logic [word_size-1:0] out_data;
    logic                 halted;

    logic [word_size-1:0] imem [256];
    logic [word_size-1:0] dmem [256];
    logic [word_size-1:0] outs [$];      // WWD values seen at the port
    logic [word_size-1:0] expected [$];
    int                   prog_len;

    tb_clock #(.period(40)) tb_clock_inst (.clk);

    cpu_core cpu_core_inst (.*);

    assign i_data = imem[i_addr[7:0]];  // combinational fetch

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [word_size-1:0] fill_word(input logic [7:0] a);
        return {~a, a};
    endfunction

    // op | rs | rt | low byte (imm8, or rd in bits 7..6)
    function automatic logic [word_size-1:0] enc(opcode_t op, int rs, int rt, int low);
        return {op, rs[1:0], rt[1:0], low[7:0]};
    endfunction

    function automatic logic [word_size-1:0] enc_r(opcode_t op, int rs, int rt, int rd);
        return enc(op, rs, rt, rd * 64);
    endfunction

    task automatic start_program();
        foreach (imem[a]) imem[a] = '0;  // NOP everywhere
        prog_len = 0;
        expected.delete();
    endtask

    task automatic put(input logic [word_size-1:0] w);
        imem[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n <= 1'b0;
        repeat (4) @(negedge clk);
        rst_n <= 1'b1;
    endtask

    // data memory responder, four-phase protocol checks and output capture
    initial begin
        logic                 req_q;
        logic                 we_q;
        logic [word_size-1:0] addr_q;
        logic [word_size-1:0] wdata_q;
        int                   ack_wait;
        void'($urandom(32'h38e2c476));
        req_q    = 1'b0;
        we_q     = 1'b0;
        addr_q   = '0;
        wdata_q  = '0;
        ack_wait = 0;
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                assert (!out_valid && !halted && !d_req)
                    else stop_run("outputs not cleared while reset is held");
                d_ack <= 1'b0;
                req_q = 1'b0;
                ack_wait = $urandom % 6;
                outs.delete();
                foreach (dmem[a]) dmem[a] = fill_word(a[7:0]);
            end else begin
                if (d_req && !req_q) begin
                    assert (!d_ack) else stop_run("d_req rose while d_ack was still high");
                end
                if (!d_req && req_q) begin
                    assert (d_ack) else stop_run("d_req dropped before d_ack was given");
                end
                if (d_req && req_q) begin
                    assert (d_addr == addr_q && d_we == we_q && d_wdata == wdata_q)
                        else stop_run("request fields changed while d_req was high");
                end
                if (d_req && !d_ack) begin
                    if (ack_wait == 0) begin
                        if (d_we) begin
                            dmem[d_addr[7:0]] = d_wdata;
                        end else begin
                            d_rdata <= dmem[d_addr[7:0]];
                        end
                        d_ack <= 1'b1;
                    end else begin
                        ack_wait--;  // random wait state
                    end
                end else if (!d_req && d_ack) begin
                    d_ack <= 1'b0;
                    ack_wait = $urandom % 6;
                end
                if (out_valid) begin
                    outs.push_back(out_data);
                end
                req_q   = d_req;
                we_q    = d_we;
                addr_q  = d_addr;
                wdata_q = d_wdata;
            end
        end
    end

    task automatic run_and_check(input string name);
        int cycles;
        apply_reset();
        cycles = 0;
        while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > 400) begin
                stop_run($sformatf("timeout at %0t: %s never raised halted", $time, name));
            end
        end
        repeat (6) @(negedge clk);  // nothing may show up after HLT
        assert (halted) else stop_run($sformatf("%s: halted fell before reset", name));
        assert (outs.size() == expected.size())
            else stop_run($sformatf("mismatch at %0t: %s gave %0d outputs, expected %0d",
                                    $time, name, outs.size(), expected.size()));
        foreach (expected[i]) begin
            assert (outs[i] == expected[i])
                else stop_run($sformatf("mismatch at %0t: %s output %0d is %h, expected %h",
                                        $time, name, i, outs[i], expected[i]));
        end
    endtask

    task automatic test_alu_forwarding();
        logic [word_size-1:0] r [4];
        start_program();
        put(enc(OP_ADI, 0, 1, 5));
        put(enc(OP_ADI, 1, 2, -3));
        put(enc_r(OP_ADD, 1, 2, 3));
        put(enc_r(OP_SUB, 3, 1, 0));  // r0 is a normal register
        put(enc(OP_WWD, 0, 0, 0));
        put(enc_r(OP_AND, 3, 1, 2));
        put(enc_r(OP_ORR, 0, 3, 1));
        put(enc(OP_WWD, 1, 0, 0));
        put(enc(OP_WWD, 2, 0, 0));
        put(enc(OP_HLT, 0, 0, 0));
        r[1] = 16'd5;
        r[2] = r[1] + 16'hfffd;  // imm8 sign-extended
        r[3] = r[1] + r[2];
        r[0] = r[3] - r[1];
        expected.push_back(r[0]);
        r[2] = r[3] & r[1];
        r[1] = r[0] | r[3];
        expected.push_back(r[1]);
        expected.push_back(r[2]);
        run_and_check("alu_forwarding");
    endtask

    task automatic test_store_load();
        start_program();
        put(enc(OP_ADI, 0, 1, 48));
        put(enc(OP_ADI, 0, 2, -7));
        put(enc(OP_SWD, 1, 2, 2));  // mem[r1 + 2] = r2
        put(enc(OP_LWD, 1, 3, 2));
        put(enc(OP_LWD, 1, 0, 5));  // never written, fill value
        put(enc(OP_WWD, 3, 0, 0));
        put(enc(OP_WWD, 0, 0, 0));
        put(enc(OP_HLT, 0, 0, 0));
        expected.push_back(16'hfff9);
        expected.push_back(fill_word(8'd48 + 8'd5));
        run_and_check("store_load");
    endtask

    task automatic test_load_use();
        start_program();
        put(enc(OP_ADI, 0, 1, 20));
        put(enc(OP_ADI, 0, 2, 9));
        put(enc(OP_SWD, 1, 2, 0));
        put(enc(OP_LWD, 1, 3, 0));
        put(enc_r(OP_ADD, 3, 1, 0));  // loaded value on rs
        put(enc(OP_LWD, 1, 2, 1));
        put(enc_r(OP_ADD, 1, 2, 3));  // loaded value on rt
        put(enc(OP_WWD, 0, 0, 0));
        put(enc(OP_WWD, 3, 0, 0));
        put(enc(OP_HLT, 0, 0, 0));
        expected.push_back(16'd9 + 16'd20);
        expected.push_back(16'd20 + fill_word(8'd21));
        run_and_check("load_use");
    endtask

    task automatic test_branch_jump();
        start_program();
        put(enc(OP_ADI, 0, 1, 3));
        put(enc(OP_ADI, 0, 2, 3));
        put(enc(OP_BNE, 1, 2, 4));  // equal, falls through
        put(enc(OP_WWD, 1, 0, 0));
        put(enc(OP_ADI, 0, 2, 1));
        put(enc(OP_BNE, 1, 2, 2));  // taken, 5 + 1 + 2
        put(enc(OP_WWD, 2, 0, 0));  // squashed
        put(enc(OP_WWD, 2, 0, 0));  // squashed
        put({OP_JMP, 12'd11});
        put(enc(OP_WWD, 1, 0, 0));
        put(enc(OP_WWD, 1, 0, 0));
        put(enc(OP_WWD, 2, 0, 0));
        put(enc(OP_HLT, 0, 0, 0));
        expected.push_back(16'd3);
        expected.push_back(16'd1);
        run_and_check("branch_jump");
    endtask

    task automatic test_halt();
        start_program();
        put(enc(OP_ADI, 0, 1, 42));
        put(enc(OP_WWD, 1, 0, 0));
        put(enc(OP_HLT, 0, 0, 0));
        put(enc(OP_WWD, 1, 0, 0));  // must never execute
        put(enc(OP_ADI, 0, 1, 1));
        put(enc(OP_WWD, 1, 0, 0));
        expected.push_back(16'd42);
        run_and_check("halt");
    endtask

    initial begin
        test_alu_forwarding();
        test_store_load();
        test_load_use();
        test_branch_jump();
        test_halt();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

`default_nettype wire
